// File: source/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// instruction fields
`define OP(i) i[31:26]
`define RS(i) i[25:21]
`define RT(i) i[20:16]
`define RD(i) i[15:11]
`define SHAMT(i) i[10:6]
`define FUNCT(i) i[5:0]
`define IMM(i) i[15:0]

// a kind is {class, index}, class in the top three bits
`define KIND_CLASS(k) k[5:3]
`define NONE 3'd0
`define CAL_R 3'd1
`define CAL_I 3'd2
`define LOAD 3'd3
`define STORE 3'd4
`define BRANCH 3'd5
`define JUMP 3'd6

`define UNKNOWN 6'b000_000
`define ADDU 6'b001_000
`define SUBU 6'b001_001
`define AND 6'b001_010
`define OR 6'b001_011
`define SLT 6'b001_100
`define ADDIU 6'b010_000
`define ORI 6'b010_001
`define LUI 6'b010_010
`define LW 6'b011_000
`define SW 6'b100_000
`define BEQ 6'b101_000
`define BNE 6'b101_001
`define J 6'b110_000

`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR 3'd3
`define ALU_SLT 3'd4
`define ALU_LUI 3'd5

`define FWD_RF 2'd0
`define FWD_M 2'd1
`define FWD_W 2'd2

// next-pc modes, picked by the D-stage instruction
`define NPC_SEQ 2'd0
`define NPC_BEQ 2'd1
`define NPC_BNE 2'd2
`define NPC_JUMP 2'd3

`define RESET_PC 32'h0000_0000
`define ZERO_REG 5'd0

`endif

// File: source/mips_pkg.sv
package mips_pkg;

	// data, address and instruction words
	typedef logic [31:0] word_t;

	// register file index
	typedef logic [4:0] reg_addr_t;

	// instruction kind, the class lives in the top three bits
	typedef logic [5:0] kind_t;

	typedef logic [2:0] alu_op_t;

	// operand source, register file or a later stage
	typedef logic [1:0] fwd_sel_t;

	// data bus master states
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		DONE
	} bus_state_t;

endpackage

// File: source/kind.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module kind (
	input mips_pkg::word_t instr,
	output mips_pkg::kind_t result
);

	logic r_type;
	logic rs_zero;
	logic shamt_zero;
	logic r_ok;

	assign r_type = (`OP(instr) == 6'b000000);
	assign rs_zero = (`RS(instr) == 5'b00000);
	assign shamt_zero = (`SHAMT(instr) == 5'b00000);

	// R-type encodings only count with a zero shift amount
	assign r_ok = r_type && shamt_zero;

	assign result =
		(r_ok && `FUNCT(instr) == 6'b100001) ? `ADDU :
		(r_ok && `FUNCT(instr) == 6'b100011) ? `SUBU :
		(r_ok && `FUNCT(instr) == 6'b100100) ? `AND :
		(r_ok && `FUNCT(instr) == 6'b100101) ? `OR :
		(r_ok && `FUNCT(instr) == 6'b101010) ? `SLT :

		(`OP(instr) == 6'b001001) ? `ADDIU :
		(`OP(instr) == 6'b001101) ? `ORI :
		(`OP(instr) == 6'b001111 && rs_zero) ? `LUI :

		(`OP(instr) == 6'b100011) ? `LW :
		(`OP(instr) == 6'b101011) ? `SW :

		(`OP(instr) == 6'b000100) ? `BEQ :
		(`OP(instr) == 6'b000101) ? `BNE :
		(`OP(instr) == 6'b000010) ? `J :

		`UNKNOWN; // the all-zero nop lands here too

endmodule

// File: source/forward.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module forward (
	input mips_pkg::reg_addr_t d_reg1,
	input mips_pkg::reg_addr_t d_reg2,
	input mips_pkg::reg_addr_t e_reg1,
	input mips_pkg::reg_addr_t e_reg2,
	input mips_pkg::reg_addr_t m_regw,
	input mips_pkg::reg_addr_t w_regw,
	input logic m_writes,
	input logic w_writes,
	output mips_pkg::fwd_sel_t fm_d1,
	output mips_pkg::fwd_sel_t fm_d2,
	output mips_pkg::fwd_sel_t fm_e1,
	output mips_pkg::fwd_sel_t fm_e2
);

	// nearest older producer wins, register zero is never bypassed
	function automatic mips_pkg::fwd_sel_t pick(
		input mips_pkg::reg_addr_t src,
		input mips_pkg::reg_addr_t mw,
		input logic mwe,
		input mips_pkg::reg_addr_t ww,
		input logic wwe
	);
		if (src == `ZERO_REG)
			return `FWD_RF;
		if (mwe && mw == src)
			return `FWD_M; // m_writes is low for loads, their data is not ready yet
		if (wwe && ww == src)
			return `FWD_W;
		return `FWD_RF;
	endfunction

	assign fm_d1 = pick(d_reg1, m_regw, m_writes, w_regw, w_writes);
	assign fm_d2 = pick(d_reg2, m_regw, m_writes, w_regw, w_writes);
	assign fm_e1 = pick(e_reg1, m_regw, m_writes, w_regw, w_writes);
	assign fm_e2 = pick(e_reg2, m_regw, m_writes, w_regw, w_writes);

endmodule

// File: source/hazard.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module hazard (
	input mips_pkg::kind_t dkind,
	input mips_pkg::kind_t ekind,
	input mips_pkg::kind_t mkind,
	input mips_pkg::reg_addr_t d_reg1,
	input mips_pkg::reg_addr_t d_reg2,
	input mips_pkg::reg_addr_t e_regw,
	input mips_pkg::reg_addr_t m_regw,
	output logic stall
);

	logic e_hit;
	logic m_hit;
	logic load_use;
	logic branch_wait;

	// unused source slots carry register zero and never match
	assign e_hit = (e_regw != `ZERO_REG) && (e_regw == d_reg1 || e_regw == d_reg2);
	assign m_hit = (m_regw != `ZERO_REG) && (m_regw == d_reg1 || m_regw == d_reg2);

	assign load_use = (`KIND_CLASS(ekind) == `LOAD) && e_hit;

	// the comparator sits in D, so it needs its operands a stage earlier
	// than the ALU does
	assign branch_wait = (`KIND_CLASS(dkind) == `BRANCH) &&
		(e_hit || ((`KIND_CLASS(mkind) == `LOAD) && m_hit));

	assign stall = load_use || branch_wait;

endmodule

// File: source/control.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module control (
	input logic clk,
	input logic arst_n,
	input mips_pkg::word_t d_instr,
	input mips_pkg::word_t e_instr,
	input mips_pkg::word_t m_instr,
	input mips_pkg::word_t w_instr,
	input logic mem_busy,
	output logic f_pc_enable,
	output logic d_enable,
	output logic e_flush,
	output logic m_enable,
	output logic w_flush,
	output logic [1:0] npc_mode,
	output logic ext_signed,
	output logic e_alusrc,
	output mips_pkg::alu_op_t e_alu_op,
	output logic m_load,
	output logic m_store,
	output logic w_rf_we,
	output logic w_regdata_mem,
	output mips_pkg::reg_addr_t d_reg1,
	output mips_pkg::reg_addr_t d_reg2,
	output mips_pkg::reg_addr_t w_regw,
	output mips_pkg::fwd_sel_t fm_d1,
	output mips_pkg::fwd_sel_t fm_d2,
	output mips_pkg::fwd_sel_t fm_e1,
	output mips_pkg::fwd_sel_t fm_e2
);

	mips_pkg::kind_t dkind, ekind, mkind, wkind;
	logic [2:0] dcls, ecls, mcls, wcls;
	mips_pkg::reg_addr_t d_regw;
	mips_pkg::reg_addr_t e_reg1, e_reg2, e_regw;
	mips_pkg::reg_addr_t m_regw;
	logic m_writes;
	logic stall;

	kind u_dkind (.instr(d_instr), .result(dkind));
	kind u_ekind (.instr(e_instr), .result(ekind));
	kind u_mkind (.instr(m_instr), .result(mkind));
	kind u_wkind (.instr(w_instr), .result(wkind));

	assign dcls = `KIND_CLASS(dkind);
	assign ecls = `KIND_CLASS(ekind);
	assign mcls = `KIND_CLASS(mkind);
	assign wcls = `KIND_CLASS(wkind);

	assign d_reg1 = (dcls == `CAL_R || dcls == `CAL_I || dcls == `LOAD ||
		dcls == `STORE || dcls == `BRANCH) ? `RS(d_instr) : `ZERO_REG;
	assign d_reg2 = (dcls == `CAL_R || dcls == `STORE || dcls == `BRANCH) ?
		`RT(d_instr) : `ZERO_REG;
	assign d_regw = (dcls == `CAL_R) ? `RD(d_instr) :
		(dcls == `CAL_I || dcls == `LOAD) ? `RT(d_instr) : `ZERO_REG;

	// register numbers follow their instruction with the same enables
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_reg1 <= `ZERO_REG;
			e_reg2 <= `ZERO_REG;
			e_regw <= `ZERO_REG;
			m_regw <= `ZERO_REG;
			w_regw <= `ZERO_REG;
		end else begin
			if (e_flush) begin
				e_reg1 <= `ZERO_REG;
				e_reg2 <= `ZERO_REG;
				e_regw <= `ZERO_REG;
			end else if (m_enable) begin
				e_reg1 <= d_reg1;
				e_reg2 <= d_reg2;
				e_regw <= d_regw;
			end
			if (m_enable)
				m_regw <= e_regw;
			w_regw <= w_flush ? `ZERO_REG : m_regw;
		end
	end

	assign npc_mode = (dkind == `BEQ) ? `NPC_BEQ :
		(dkind == `BNE) ? `NPC_BNE :
		(dcls == `JUMP) ? `NPC_JUMP : `NPC_SEQ;
	assign ext_signed = (dkind != `ORI);

	assign e_alusrc = (ecls == `CAL_I || ecls == `LOAD || ecls == `STORE);

	always_comb begin
		case (ekind)
			`SUBU: e_alu_op = `ALU_SUB;
			`AND: e_alu_op = `ALU_AND;
			`OR, `ORI: e_alu_op = `ALU_OR;
			`SLT: e_alu_op = `ALU_SLT;
			`LUI: e_alu_op = `ALU_LUI;
			default: e_alu_op = `ALU_ADD; // addu, addiu and address generation
		endcase
	end

	assign m_load = (mcls == `LOAD);
	assign m_store = (mcls == `STORE);
	assign m_writes = (mcls == `CAL_R || mcls == `CAL_I);

	assign w_rf_we = (wcls == `CAL_R || wcls == `CAL_I || wcls == `LOAD);
	assign w_regdata_mem = (wcls == `LOAD);

	forward u_forward (
		.d_reg1(d_reg1),
		.d_reg2(d_reg2),
		.e_reg1(e_reg1),
		.e_reg2(e_reg2),
		.m_regw(m_regw),
		.w_regw(w_regw),
		.m_writes(m_writes),
		.w_writes(w_rf_we),
		.fm_d1(fm_d1),
		.fm_d2(fm_d2),
		.fm_e1(fm_e1),
		.fm_e2(fm_e2)
	);

	hazard u_hazard (
		.dkind(dkind),
		.ekind(ekind),
		.mkind(mkind),
		.d_reg1(d_reg1),
		.d_reg2(d_reg2),
		.e_regw(e_regw),
		.m_regw(m_regw),
		.stall(stall)
	);

	// a bus wait freezes F to M and drains W, a hazard only bubbles E
	assign f_pc_enable = !stall && !mem_busy;
	assign d_enable = !stall && !mem_busy;
	assign e_flush = stall && !mem_busy;
	assign m_enable = !mem_busy;
	assign w_flush = mem_busy;

endmodule

// File: source/dm_bus.sv
`timescale 1ns/100ps

module dm_bus (
	input logic clk,
	input logic arst_n,
	input logic load,
	input logic store,
	input mips_pkg::word_t addr,
	input mips_pkg::word_t wdata,
	output logic busy,
	output mips_pkg::word_t rdata,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output mips_pkg::word_t wb_adr,
	output mips_pkg::word_t wb_dat_o,
	output logic [3:0] wb_sel,
	input mips_pkg::word_t wb_dat_i,
	input logic wb_ack
);

	mips_pkg::bus_state_t state;
	logic start;

	assign start = (state == mips_pkg::IDLE) && (load || store);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mips_pkg::IDLE;
			wb_we <= 1'b0;
		end else begin
			case (state)
				mips_pkg::IDLE: if (start) begin
					state <= mips_pkg::ACCESS;
					wb_we <= store;
				end
				mips_pkg::ACCESS: if (wb_ack) begin
					state <= mips_pkg::DONE;
					wb_we <= 1'b0;
				end
				default: state <= mips_pkg::IDLE; // M moves on while the bus rests
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			wb_adr <= addr;
			wb_dat_o <= wdata;
		end
		if (state == mips_pkg::ACCESS && wb_ack)
			rdata <= wb_dat_i; // held until the next ack, W reads it
	end

	assign wb_cyc = (state == mips_pkg::ACCESS);
	assign wb_stb = wb_cyc;
	assign wb_sel = 4'hf;
	assign busy = start || (state == mips_pkg::ACCESS);

endmodule

// File: source/mips.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module mips (
	input logic clk,
	input logic arst_n,
	output mips_pkg::word_t imem_addr,
	input mips_pkg::word_t imem_data,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output mips_pkg::word_t wb_adr,
	output mips_pkg::word_t wb_dat_o,
	output logic [3:0] wb_sel,
	input mips_pkg::word_t wb_dat_i,
	input logic wb_ack
);

	mips_pkg::word_t f_pc, seq_pc, next_pc, br_target, j_target;
	mips_pkg::word_t d_instr, d_pc, d_pc4, d_ext, rf_rd1, rf_rd2, d_a, d_b;
	mips_pkg::word_t e_instr, e_a, e_b, e_imm, e_a_f, e_b_f, alu_b, alu_y;
	mips_pkg::word_t m_instr, m_alu, m_wdata, m_rdata;
	mips_pkg::word_t w_instr, w_alu, w_result;
	mips_pkg::word_t rf [0:31];
	logic f_pc_enable, d_enable, e_flush, m_enable, w_flush;
	logic [1:0] npc_mode;
	logic ext_signed, e_alusrc, m_load, m_store, w_rf_we, w_regdata_mem, mem_busy;
	mips_pkg::alu_op_t e_alu_op;
	mips_pkg::reg_addr_t d_reg1, d_reg2, w_regw;
	mips_pkg::fwd_sel_t fm_d1, fm_d2, fm_e1, fm_e2;

	control u_control (
		.clk(clk), .arst_n(arst_n),
		.d_instr(d_instr), .e_instr(e_instr), .m_instr(m_instr), .w_instr(w_instr),
		.mem_busy(mem_busy),
		.f_pc_enable(f_pc_enable), .d_enable(d_enable), .e_flush(e_flush),
		.m_enable(m_enable), .w_flush(w_flush),
		.npc_mode(npc_mode), .ext_signed(ext_signed),
		.e_alusrc(e_alusrc), .e_alu_op(e_alu_op),
		.m_load(m_load), .m_store(m_store),
		.w_rf_we(w_rf_we), .w_regdata_mem(w_regdata_mem),
		.d_reg1(d_reg1), .d_reg2(d_reg2), .w_regw(w_regw),
		.fm_d1(fm_d1), .fm_d2(fm_d2), .fm_e1(fm_e1), .fm_e2(fm_e2)
	);

	dm_bus u_dm_bus (
		.clk(clk), .arst_n(arst_n),
		.load(m_load), .store(m_store),
		.addr(m_alu), .wdata(m_wdata),
		.busy(mem_busy), .rdata(m_rdata),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

	assign imem_addr = f_pc;
	assign seq_pc = f_pc + 32'd4;

	// the slot after the branch is already in F, so targets replace its successor
	assign d_pc4 = d_pc + 32'd4;
	assign br_target = d_pc4 + {{14{d_instr[15]}}, `IMM(d_instr), 2'b00};
	assign j_target = {d_pc4[31:28], d_instr[25:0], 2'b00};

	always_comb begin
		case (npc_mode)
			`NPC_BEQ: next_pc = (d_a == d_b) ? br_target : seq_pc;
			`NPC_BNE: next_pc = (d_a != d_b) ? br_target : seq_pc;
			`NPC_JUMP: next_pc = j_target;
			default: next_pc = seq_pc;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			f_pc <= `RESET_PC;
			d_instr <= '0;
			e_instr <= '0;
			m_instr <= '0;
			w_instr <= '0;
		end else begin
			if (f_pc_enable)
				f_pc <= next_pc;
			if (d_enable)
				d_instr <= imem_data;
			if (e_flush)
				e_instr <= '0;
			else if (m_enable)
				e_instr <= d_instr;
			if (m_enable)
				m_instr <= e_instr;
			w_instr <= w_flush ? '0 : m_instr;
		end
	end

	// a W write reaches D through the fm_d selects
	assign rf_rd1 = (d_reg1 == `ZERO_REG) ? '0 : rf[d_reg1];
	assign rf_rd2 = (d_reg2 == `ZERO_REG) ? '0 : rf[d_reg2];

	always_ff @(posedge clk) begin
		if (w_rf_we && w_regw != `ZERO_REG)
			rf[w_regw] <= w_result;
	end

	assign d_a = (fm_d1 == `FWD_M) ? m_alu : (fm_d1 == `FWD_W) ? w_result : rf_rd1;
	assign d_b = (fm_d2 == `FWD_M) ? m_alu : (fm_d2 == `FWD_W) ? w_result : rf_rd2;
	assign d_ext = ext_signed ? {{16{d_instr[15]}}, `IMM(d_instr)} : {16'h0, `IMM(d_instr)};

	assign e_a_f = (fm_e1 == `FWD_M) ? m_alu : (fm_e1 == `FWD_W) ? w_result : e_a;
	assign e_b_f = (fm_e2 == `FWD_M) ? m_alu : (fm_e2 == `FWD_W) ? w_result : e_b;

	always_ff @(posedge clk) begin
		if (d_enable)
			d_pc <= f_pc;
		if (m_enable) begin
			e_a <= d_a;
			e_b <= d_b;
			e_imm <= d_ext;
		end else begin
			e_a <= e_a_f; // a frozen E keeps what W bypasses before W drains
			e_b <= e_b_f;
		end
		if (m_enable) begin
			m_alu <= alu_y;
			m_wdata <= e_b_f;
		end
		w_alu <= m_alu;
	end

	assign alu_b = e_alusrc ? e_imm : e_b_f;

	always_comb begin
		case (e_alu_op)
			`ALU_SUB: alu_y = e_a_f - alu_b;
			`ALU_AND: alu_y = e_a_f & alu_b;
			`ALU_OR: alu_y = e_a_f | alu_b;
			`ALU_SLT: alu_y = {31'b0, $signed(e_a_f) < $signed(alu_b)};
			`ALU_LUI: alu_y = {alu_b[15:0], 16'h0};
			default: alu_y = e_a_f + alu_b;
		endcase
	end

	assign w_result = w_regdata_mem ? m_rdata : w_alu;

endmodule

// File: test/mips_sva.sv
`timescale 1ns/100ps

module mips_sva (
	input logic clk,
	input logic arst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input mips_pkg::word_t wb_adr,
	input mips_pkg::word_t wb_dat_o,
	input logic wb_ack
);

	logic stb_bad = 1'b0;
	logic hold_bad = 1'b0;
	logic gap_bad = 1'b0;
	logic reset_bad = 1'b0;
	logic failed;

	assign failed = stb_bad || hold_bad || gap_bad || reset_bad; // sticky once any rule breaks

	stb_in_cycle: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
	else begin
		stb_bad = 1'b1;
		$error("wb_stb is high outside a bus cycle");
	end

	// a slave may take its time, the request must not change under it
	hold_request: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we))
	else begin
		hold_bad = 1'b1;
		$error("wb_adr, wb_dat_o or wb_we changed before wb_ack");
	end

	gap_after_ack: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_cyc)
	else begin
		gap_bad = 1'b1;
		$error("wb_cyc stayed high in the cycle after wb_ack");
	end

	idle_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_cyc && !wb_we)
	else begin
		reset_bad = 1'b1;
		$error("bus is active during reset");
	end

endmodule

bind mips mips_sva u_sva (
	.clk(clk),
	.arst_n(arst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_dat_o(wb_dat_o),
	.wb_ack(wb_ack)
);

// File: test/mips_tb.sv
`timescale 1ns/100ps

module mips_tb;

	localparam int N_STORES = 13;
	localparam int MAX_CYCLES = 60 * (5 + 3) + 10; // 60 instructions at 5 stages and 3 waits

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	mips_pkg::word_t imem_addr;
	mips_pkg::word_t imem_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	mips_pkg::word_t wb_adr;
	mips_pkg::word_t wb_dat_o;
	logic [3:0] wb_sel;
	mips_pkg::word_t wb_dat_i = '0;
	logic wb_ack = 1'b0;

	logic [31:0] rom [0:63];
	logic [31:0] ram [0:255];
	logic [63:0] expected [0:N_STORES-1]; // {address, data} in program order
	int store_idx = 0;
	int cycles = 0;
	logic [15:0] lfsr = 16'd35688;
	logic [1:0] waits = 2'd0;
	logic in_access = 1'b0;

	mips UUT (
		.clk(clk), .arst_n(arst_n),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

	assign imem_data = rom[imem_addr[7:2]];

	function automatic logic [31:0] rtype(input logic [4:0] rs, rt, rd, input logic [5:0] funct);
		return {6'b000000, rs, rt, rd, 5'b00000, funct};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [31:0] target);
		return {6'b000010, target[27:2]};
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic fail_run();
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic load_program();
		for (int i = 0; i < 64; i++)
			rom[i] = 32'h0;
		rom[0] = itype(6'h0f, 5'd0, 5'd1, 16'h1234); // lui $1
		rom[1] = itype(6'h0d, 5'd1, 5'd1, 16'h5678); // ori $1, $1
		rom[2] = itype(6'h09, 5'd0, 5'd2, 16'h0f0f); // addiu $2
		rom[3] = rtype(5'd1, 5'd2, 5'd3, 6'h21); // addu $3, $1, $2
		rom[4] = rtype(5'd2, 5'd1, 5'd4, 6'h23); // subu $4, $2, $1
		rom[5] = rtype(5'd1, 5'd2, 5'd5, 6'h24); // and $5, $1, $2
		rom[6] = rtype(5'd4, 5'd2, 5'd6, 6'h25); // or $6, $4, $2
		rom[7] = rtype(5'd4, 5'd1, 5'd7, 6'h2a); // slt $7, $4, $1
		rom[8] = rtype(5'd1, 5'd4, 5'd8, 6'h2a); // slt $8, $1, $4
		rom[9] = itype(6'h2b, 5'd0, 5'd8, 16'h011c); // store data bypassed from M
		rom[10] = itype(6'h2b, 5'd0, 5'd1, 16'h0100);
		rom[11] = itype(6'h2b, 5'd0, 5'd2, 16'h0104);
		rom[12] = itype(6'h2b, 5'd0, 5'd3, 16'h0108);
		rom[13] = itype(6'h2b, 5'd0, 5'd4, 16'h010c);
		rom[14] = itype(6'h2b, 5'd0, 5'd5, 16'h0110);
		rom[15] = itype(6'h2b, 5'd0, 5'd6, 16'h0114);
		rom[16] = itype(6'h2b, 5'd0, 5'd7, 16'h0118);
		rom[17] = itype(6'h23, 5'd0, 5'd9, 16'h0080); // lw $9 whose result is used at once
		rom[18] = rtype(5'd9, 5'd1, 5'd10, 6'h21);
		rom[19] = itype(6'h2b, 5'd0, 5'd10, 16'h0120);
		rom[20] = itype(6'h09, 5'd0, 5'd11, 16'h0005);
		rom[21] = itype(6'h09, 5'd0, 5'd12, 16'h0005);
		rom[22] = itype(6'h04, 5'd11, 5'd12, 16'h0002); // beq taken while $12 is still in E
		rom[23] = itype(6'h09, 5'd0, 5'd13, 16'h0077); // delay slot
		rom[24] = itype(6'h2b, 5'd0, 5'd13, 16'h01f0); // skipped
		rom[25] = itype(6'h2b, 5'd0, 5'd13, 16'h0124);
		rom[26] = itype(6'h04, 5'd11, 5'd1, 16'h0002); // beq not taken
		rom[27] = itype(6'h09, 5'd0, 5'd14, 16'h0055);
		rom[28] = itype(6'h2b, 5'd0, 5'd14, 16'h0128);
		rom[29] = itype(6'h05, 5'd11, 5'd14, 16'h0002); // bne taken
		rom[30] = itype(6'h09, 5'd0, 5'd15, 16'h0066);
		rom[31] = itype(6'h2b, 5'd0, 5'd15, 16'h01f4); // skipped
		rom[32] = itype(6'h2b, 5'd0, 5'd15, 16'h012c);
		rom[33] = jtype(32'h0000_0090);
		rom[34] = itype(6'h0d, 5'd0, 5'd16, 16'h0099);
		rom[35] = itype(6'h2b, 5'd0, 5'd16, 16'h01f8); // skipped
		rom[36] = itype(6'h2b, 5'd0, 5'd16, 16'h0130);
		rom[37] = jtype(32'h0000_0094); // park here
	endtask

	task automatic load_expected();
		expected[0] = {32'h0000_011c, 32'h0000_0000};
		expected[1] = {32'h0000_0100, 32'h1234_5678};
		expected[2] = {32'h0000_0104, 32'h0000_0f0f};
		expected[3] = {32'h0000_0108, 32'h1234_6587};
		expected[4] = {32'h0000_010c, 32'hedcb_b897};
		expected[5] = {32'h0000_0110, 32'h0000_0608};
		expected[6] = {32'h0000_0114, 32'hedcb_bf9f};
		expected[7] = {32'h0000_0118, 32'h0000_0001};
		expected[8] = {32'h0000_0120, 32'h3313_d13b}; // ram word 0x20 plus $1
		expected[9] = {32'h0000_0124, 32'h0000_0077};
		expected[10] = {32'h0000_0128, 32'h0000_0055};
		expected[11] = {32'h0000_012c, 32'h0000_0066};
		expected[12] = {32'h0000_0130, 32'h0000_0099};
	endtask

	task automatic check_store();
		if (store_idx >= N_STORES) begin
			$display("an unexpected store to address %h reached the bus", wb_adr);
			fail_run();
		end else begin
			assert (wb_adr == expected[store_idx][63:32]) else begin
				$display("CHECK FAILED: wb_adr = %h, expected %h", wb_adr,
					expected[store_idx][63:32]);
				fail_run();
			end
			assert (wb_dat_o == expected[store_idx][31:0]) else begin
				$display("CHECK FAILED: wb_dat_o = %h, expected %h", wb_dat_o,
					expected[store_idx][31:0]);
				fail_run();
			end
			store_idx++;
		end
	endtask

	initial begin
		forever #10 clk = ~clk;
	end

	// Wishbone slave that adds 0 to 3 wait states per access
	always @(negedge clk) begin
		if (!arst_n || wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!in_access) begin
				in_access = 1'b1;
				lfsr = lfsr_step(lfsr);
				waits[0] = lfsr[0];
				lfsr = lfsr_step(lfsr);
				waits[1] = lfsr[0];
			end
			if (waits == 2'd0) begin
				assert (wb_sel == 4'hf) else begin
					$display("CHECK FAILED: wb_sel = %h, expected %h", wb_sel, 4'hf);
					fail_run();
				end
				in_access = 1'b0;
				wb_ack = 1'b1;
				if (wb_we) begin
					check_store();
					ram[wb_adr[9:2]] = wb_dat_o;
				end else begin
					wb_dat_i = ram[wb_adr[9:2]];
				end
			end else begin
				waits = waits - 2'd1;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d stores seen", cycles, store_idx,
				N_STORES);
			fail_run();
		end else if (UUT.u_sva.failed) begin
			$display("a bus protocol assertion failed");
			fail_run();
		end
	end

	initial begin
		load_program();
		load_expected();
		for (int i = 0; i < 256; i++)
			ram[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		assert (imem_addr == 32'h0000_0000) else begin
			$display("CHECK FAILED: imem_addr = %h, expected %h", imem_addr, 32'h0);
			fail_run();
		end
		assert (!wb_cyc && !wb_stb && !wb_we) else begin
			$display("the data bus is not idle right after reset");
			fail_run();
		end
		wait (store_idx == N_STORES);
		repeat (20) @(negedge clk); // a late or repeated store would still show up here
		if (UUT.u_sva.failed) begin
			$display("a bus protocol assertion failed");
			fail_run();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: mips.f
+incdir+source
source/mips_pkg.sv
source/kind.sv
source/forward.sv
source/hazard.sv
source/control.sv
source/dm_bus.sv
source/mips.sv
test/mips_sva.sv
test/mips_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module mips_tb -f mips.f
	@out=$$(./obj_dir/Vmips_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
